// File: cfg_pkg.sv
package cfg_pkg;

	typedef logic [4:0]  addr_t;
	typedef logic [31:0] word_t;
	typedef logic [3:0]  strb_t;
	typedef logic [47:0] mac_t;
	typedef logic [31:0] ip_t;
	typedef logic [1:0]  resp_t;

	localparam resp_t RESP_OKAY = 2'b00;

	// register map, byte addresses
	typedef enum addr_t {
		REG_ENA     = 5'h00,
		REG_IP      = 5'h04,
		REG_GATEWAY = 5'h08,
		REG_NETMASK = 5'h0C,
		REG_MAC_HI  = 5'h10,
		REG_MAC_LO  = 5'h14
	} reg_addr_e;

	typedef enum logic [1:0] {
		WR_RESET,
		WR_IDLE,
		WR_DATA,
		WR_RESP
	} wr_state_e;

	typedef enum logic [1:0] {
		RD_RESET,
		RD_IDLE,
		RD_DATA
	} rd_state_e;

	// addresses used while the enable bit is clear
	localparam ip_t  DEF_IP      = 32'h0A0A_0EF0;
	localparam ip_t  DEF_GATEWAY = 32'h0A0A_0E0A;
	localparam ip_t  DEF_NETMASK = 32'hFFFF_FF00;
	localparam mac_t DEF_MAC     = 48'h203A_B490_E564;

endpackage

// File: cfg_write_channel.sv
`timescale 1ns/1ps
module cfg_write_channel (
	input  logic           ACLK,
	input  logic           ARESET,
	input  cfg_pkg::addr_t awaddr,
	input  logic           awvalid,
	output logic           awready,
	input  cfg_pkg::word_t wdata,
	input  cfg_pkg::strb_t wstrb,
	input  logic           wvalid,
	output logic           wready,
	output cfg_pkg::resp_t bresp,
	output logic           bvalid,
	input  logic           bready,
	output logic           wr_en,
	output cfg_pkg::addr_t wr_addr,
	output cfg_pkg::word_t wr_data,
	output cfg_pkg::strb_t wr_strb
);
	import cfg_pkg::*;

	wr_state_e state;
	wr_state_e state_next;
	addr_t     addr_q;
	logic      aw_hs;

	assign awready = (state == WR_IDLE);
	assign wready  = (state == WR_DATA);
	assign bvalid  = (state == WR_RESP);
	assign bresp   = RESP_OKAY;
	assign aw_hs   = awvalid & awready;

	// one cycle pulse on the data handshake
	assign wr_en   = wvalid & wready;
	assign wr_addr = addr_q;
	assign wr_data = wdata;
	assign wr_strb = wstrb;

	always_ff @(posedge ACLK) begin
		if (ARESET) begin
			state <= WR_RESET;
		end else begin
			state <= state_next;
		end
	end

	always_comb begin
		state_next = state;
		case (state)
			WR_IDLE: begin
				if (awvalid) begin
					state_next = WR_DATA;
				end
			end
			WR_DATA: begin
				if (wvalid) begin
					state_next = WR_RESP;
				end
			end
			WR_RESP: begin
				if (bready) begin
					state_next = WR_IDLE;
				end
			end
			default: state_next = WR_IDLE;
		endcase
	end

	always_ff @(posedge ACLK) begin
		if (aw_hs) begin
			addr_q <= awaddr;
		end
	end

	// response held until the master takes it
	a_bvalid_hold: assert property (@(posedge ACLK) disable iff (ARESET)
		bvalid && !bready |=> bvalid);

endmodule

// File: cfg_register_file.sv
`timescale 1ns/1ps
module cfg_register_file (
	input  logic           ACLK,
	input  logic           ARESET,
	input  logic           wr_en,
	input  cfg_pkg::addr_t wr_addr,
	input  cfg_pkg::word_t wr_data,
	input  cfg_pkg::strb_t wr_strb,
	input  cfg_pkg::addr_t rd_addr,
	output cfg_pkg::word_t rd_data,
	output cfg_pkg::word_t reg_ena,
	output cfg_pkg::ip_t   reg_ip,
	output cfg_pkg::ip_t   reg_gateway,
	output cfg_pkg::ip_t   reg_netmask,
	output cfg_pkg::mac_t  reg_mac
);
	import cfg_pkg::*;

	word_t ena_q;
	word_t ip_q;
	word_t gateway_q;
	word_t netmask_q;
	word_t mac_hi_q;
	word_t mac_lo_q;

	// strobed bytes take new data, the rest keep old
	function automatic word_t merge(word_t old_w, word_t new_w, strb_t strb);
		word_t res;
		res = old_w;
		for (int i = 0; i < $bits(strb_t); i++) begin
			if (strb[i]) begin
				res[8*i +: 8] = new_w[8*i +: 8];
			end
		end
		return res;
	endfunction

	always_ff @(posedge ACLK) begin
		if (ARESET) begin
			ena_q     <= '0;
			ip_q      <= '0;
			gateway_q <= '0;
			netmask_q <= '0;
			mac_hi_q  <= '0;
			mac_lo_q  <= '0;
		end else if (wr_en) begin
			case (wr_addr)
				REG_ENA:     ena_q     <= merge(ena_q, wr_data, wr_strb);
				REG_IP:      ip_q      <= merge(ip_q, wr_data, wr_strb);
				REG_GATEWAY: gateway_q <= merge(gateway_q, wr_data, wr_strb);
				REG_NETMASK: netmask_q <= merge(netmask_q, wr_data, wr_strb);
				REG_MAC_HI:  mac_hi_q  <= merge(mac_hi_q, wr_data, wr_strb);
				REG_MAC_LO:  mac_lo_q  <= merge(mac_lo_q, wr_data, wr_strb);
				// unmapped, dropped
				default: ;
			endcase
		end
	end

	always_comb begin
		case (rd_addr)
			REG_ENA:     rd_data = ena_q;
			REG_IP:      rd_data = ip_q;
			REG_GATEWAY: rd_data = gateway_q;
			REG_NETMASK: rd_data = netmask_q;
			REG_MAC_HI:  rd_data = mac_hi_q;
			REG_MAC_LO:  rd_data = mac_lo_q;
			default:     rd_data = '0;
		endcase
	end

	assign reg_ena     = ena_q;
	assign reg_ip      = ip_q;
	assign reg_gateway = gateway_q;
	assign reg_netmask = netmask_q;
	// only the low half of the high register is part of the MAC
	assign reg_mac     = {mac_hi_q[15:0], mac_lo_q};

	// address from the write channel must be settled at the pulse
	a_wr_addr_known: assert property (@(posedge ACLK) disable iff (ARESET)
		wr_en |-> !$isunknown(wr_addr));

endmodule

// File: cfg_read_channel.sv
`timescale 1ns/1ps
module cfg_read_channel (
	input  logic           ACLK,
	input  logic           ARESET,
	input  cfg_pkg::addr_t araddr,
	input  logic           arvalid,
	output logic           arready,
	output cfg_pkg::word_t rdata,
	output cfg_pkg::resp_t rresp,
	output logic           rvalid,
	input  logic           rready,
	output cfg_pkg::addr_t rd_addr,
	input  cfg_pkg::word_t rd_data
);
	import cfg_pkg::*;

	rd_state_e state;
	rd_state_e state_next;
	logic      ar_hs;

	assign arready = (state == RD_IDLE);
	assign rvalid  = (state == RD_DATA);
	assign rresp   = RESP_OKAY;
	assign ar_hs   = arvalid & arready;
	assign rd_addr = araddr;

	always_ff @(posedge ACLK) begin
		if (ARESET) begin
			state <= RD_RESET;
		end else begin
			state <= state_next;
		end
	end

	always_comb begin
		state_next = state;
		case (state)
			RD_IDLE: begin
				if (arvalid) begin
					state_next = RD_DATA;
				end
			end
			RD_DATA: begin
				if (rready) begin
					state_next = RD_IDLE;
				end
			end
			default: state_next = RD_IDLE;
		endcase
	end

	// decoded word taken at the address handshake
	always_ff @(posedge ACLK) begin
		if (ARESET) begin
			rdata <= '0;
		end else if (ar_hs) begin
			rdata <= rd_data;
		end
	end

	a_rdata_stable: assert property (@(posedge ACLK) disable iff (ARESET)
		rvalid && !rready |=> rvalid && $stable(rdata));

endmodule

// File: cfg_output_stage.sv
`timescale 1ns/1ps
module cfg_output_stage #(
	parameter cfg_pkg::ip_t  ip_addr      = cfg_pkg::DEF_IP,
	parameter cfg_pkg::ip_t  gateway_addr = cfg_pkg::DEF_GATEWAY,
	parameter cfg_pkg::ip_t  netmask_addr = cfg_pkg::DEF_NETMASK,
	parameter cfg_pkg::mac_t mac_addr     = cfg_pkg::DEF_MAC
) (
	input  logic           ACLK,
	input  logic           ARESET,
	input  cfg_pkg::word_t reg_ena,
	input  cfg_pkg::ip_t   reg_ip,
	input  cfg_pkg::ip_t   reg_gateway,
	input  cfg_pkg::ip_t   reg_netmask,
	input  cfg_pkg::mac_t  reg_mac,
	output cfg_pkg::ip_t   cfg_ip,
	output cfg_pkg::ip_t   cfg_gateway,
	output cfg_pkg::ip_t   cfg_netmask,
	output cfg_pkg::mac_t  cfg_mac
);
	import cfg_pkg::*;

	logic ena_q;
	ip_t  ip_q;
	ip_t  gateway_q;
	ip_t  netmask_q;
	mac_t mac_q;

	// one register stage between the bus side and the network core
	always_ff @(posedge ACLK) begin
		if (ARESET) begin
			ena_q     <= 1'b0;
			ip_q      <= '0;
			gateway_q <= '0;
			netmask_q <= '0;
			mac_q     <= '0;
		end else begin
			ena_q     <= reg_ena[0];
			ip_q      <= reg_ip;
			gateway_q <= reg_gateway;
			netmask_q <= reg_netmask;
			mac_q     <= reg_mac;
		end
	end

	// defaults until software sets the enable bit
	assign cfg_ip      = ena_q ? ip_q : ip_addr;
	assign cfg_gateway = ena_q ? gateway_q : gateway_addr;
	assign cfg_netmask = ena_q ? netmask_q : netmask_addr;
	assign cfg_mac     = ena_q ? mac_q : mac_addr;

endmodule

// File: net_cfg_top.sv
`timescale 1ns/1ps
module net_cfg_top #(
	parameter cfg_pkg::ip_t  ip_addr      = cfg_pkg::DEF_IP,
	parameter cfg_pkg::ip_t  gateway_addr = cfg_pkg::DEF_GATEWAY,
	parameter cfg_pkg::ip_t  netmask_addr = cfg_pkg::DEF_NETMASK,
	parameter cfg_pkg::mac_t mac_addr     = cfg_pkg::DEF_MAC
) (
	input  logic           ACLK,
	input  logic           ARESET,
	input  cfg_pkg::addr_t awaddr,
	input  logic           awvalid,
	output logic           awready,
	input  cfg_pkg::word_t wdata,
	input  cfg_pkg::strb_t wstrb,
	input  logic           wvalid,
	output logic           wready,
	output cfg_pkg::resp_t bresp,
	output logic           bvalid,
	input  logic           bready,
	input  cfg_pkg::addr_t araddr,
	input  logic           arvalid,
	output logic           arready,
	output cfg_pkg::word_t rdata,
	output cfg_pkg::resp_t rresp,
	output logic           rvalid,
	input  logic           rready,
	output cfg_pkg::ip_t   cfg_ip,
	output cfg_pkg::ip_t   cfg_gateway,
	output cfg_pkg::ip_t   cfg_netmask,
	output cfg_pkg::mac_t  cfg_mac
);
	import cfg_pkg::*;

	logic  wr_en;
	addr_t wr_addr;
	word_t wr_data;
	strb_t wr_strb;
	addr_t rd_addr;
	word_t rd_data;
	word_t reg_ena;
	ip_t   reg_ip;
	ip_t   reg_gateway;
	ip_t   reg_netmask;
	mac_t  reg_mac;

	cfg_write_channel u_write (
		.ACLK    (ACLK),
		.ARESET  (ARESET),
		.awaddr  (awaddr),
		.awvalid (awvalid),
		.awready (awready),
		.wdata   (wdata),
		.wstrb   (wstrb),
		.wvalid  (wvalid),
		.wready  (wready),
		.bresp   (bresp),
		.bvalid  (bvalid),
		.bready  (bready),
		.wr_en   (wr_en),
		.wr_addr (wr_addr),
		.wr_data (wr_data),
		.wr_strb (wr_strb)
	);

	cfg_register_file u_regs (
		.ACLK        (ACLK),
		.ARESET      (ARESET),
		.wr_en       (wr_en),
		.wr_addr     (wr_addr),
		.wr_data     (wr_data),
		.wr_strb     (wr_strb),
		.rd_addr     (rd_addr),
		.rd_data     (rd_data),
		.reg_ena     (reg_ena),
		.reg_ip      (reg_ip),
		.reg_gateway (reg_gateway),
		.reg_netmask (reg_netmask),
		.reg_mac     (reg_mac)
	);

	cfg_read_channel u_read (
		.ACLK    (ACLK),
		.ARESET  (ARESET),
		.araddr  (araddr),
		.arvalid (arvalid),
		.arready (arready),
		.rdata   (rdata),
		.rresp   (rresp),
		.rvalid  (rvalid),
		.rready  (rready),
		.rd_addr (rd_addr),
		.rd_data (rd_data)
	);

	cfg_output_stage #(
		.ip_addr      (ip_addr),
		.gateway_addr (gateway_addr),
		.netmask_addr (netmask_addr),
		.mac_addr     (mac_addr)
	) u_out (
		.ACLK        (ACLK),
		.ARESET      (ARESET),
		.reg_ena     (reg_ena),
		.reg_ip      (reg_ip),
		.reg_gateway (reg_gateway),
		.reg_netmask (reg_netmask),
		.reg_mac     (reg_mac),
		.cfg_ip      (cfg_ip),
		.cfg_gateway (cfg_gateway),
		.cfg_netmask (cfg_netmask),
		.cfg_mac     (cfg_mac)
	);

endmodule

// File: tb_checks.svh
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

int value_errors = 0;
int timeout_errors = 0;
int protocol_errors = 0;
logic [31:0] lcg_state = 32'hdc84_fe6b;

localparam int WAIT_LIMIT   = 64;
localparam int FLAG_AWREADY = 0;
localparam int FLAG_WREADY  = 1;
localparam int FLAG_BVALID  = 2;
localparam int FLAG_ARREADY = 3;
localparam int FLAG_RVALID  = 4;

function automatic logic [31:0] lcg_next();
	lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
	return lcg_state;
endfunction

task automatic check_word(input string name, input word_t got, input word_t exp);
	if (got !== exp) begin
		value_errors++;
		$display("CHECK FAILED at time %0t: %s is %h, expected %h", $time, name, got, exp);
	end
endtask

task automatic check_ip(input string name, input ip_t got, input ip_t exp);
	if (got !== exp) begin
		value_errors++;
		$display("CHECK FAILED at time %0t: %s is %h, expected %h", $time, name, got, exp);
	end
endtask

task automatic check_mac(input string name, input mac_t got, input mac_t exp);
	if (got !== exp) begin
		value_errors++;
		$display("CHECK FAILED at time %0t: %s is %h, expected %h", $time, name, got, exp);
	end
endtask

task automatic check_resp(input string name, input resp_t got, input resp_t exp);
	if (got !== exp) begin
		value_errors++;
		$display("CHECK FAILED at time %0t: %s is %h, expected %h", $time, name, got, exp);
	end
endtask

function automatic void protocol_fail(input string what);
	protocol_errors++;
	$display("protocol error at time %0t: %s", $time, what);
endfunction

function automatic logic flag_value(input int sel);
	case (sel)
		FLAG_AWREADY: return awready;
		FLAG_WREADY:  return wready;
		FLAG_BVALID:  return bvalid;
		FLAG_ARREADY: return arready;
		default:      return rvalid;
	endcase
endfunction

// flags change on rising edges and are sampled at falling ones
task automatic wait_flag(input int sel, input string what);
	int n;
	n = 0;
	@(negedge ACLK);
	while (flag_value(sel) !== 1'b1 && n < WAIT_LIMIT) begin
		@(negedge ACLK);
		n++;
	end
	if (flag_value(sel) !== 1'b1) begin
		timeout_errors++;
		$display("timed out at time %0t waiting for %s", $time, what);
	end
endtask

task automatic bus_write(input addr_t addr, input word_t data, input strb_t strb,
		input int hold, output resp_t resp);
	@(posedge ACLK);
	awaddr  <= addr;
	awvalid <= 1'b1;
	wait_flag(FLAG_AWREADY, "awready");
	@(posedge ACLK);
	awvalid <= 1'b0;
	wdata   <= data;
	wstrb   <= strb;
	wvalid  <= 1'b1;
	wait_flag(FLAG_WREADY, "wready");
	@(posedge ACLK);
	wvalid <= 1'b0;
	wait_flag(FLAG_BVALID, "bvalid");
	// master not ready yet
	repeat (hold) begin
		@(negedge ACLK);
		if (bvalid !== 1'b1) protocol_fail("bvalid dropped before bready");
	end
	@(posedge ACLK);
	bready <= 1'b1;
	@(negedge ACLK);
	if (bvalid !== 1'b1) protocol_fail("bvalid low when bready was given");
	resp = bresp;
	@(posedge ACLK);
	bready <= 1'b0;
	@(negedge ACLK);
	if (bvalid !== 1'b0) protocol_fail("bvalid still high after the response handshake");
endtask

task automatic bus_read(input addr_t addr, input int hold, output word_t data,
		output resp_t resp);
	@(posedge ACLK);
	araddr  <= addr;
	arvalid <= 1'b1;
	wait_flag(FLAG_ARREADY, "arready");
	@(posedge ACLK);
	arvalid <= 1'b0;
	// another address decodes while the captured word waits
	araddr  <= ~addr;
	wait_flag(FLAG_RVALID, "rvalid");
	data = rdata;
	resp = rresp;
	// data has to sit still while rready is low
	repeat (hold) begin
		@(negedge ACLK);
		if (rvalid !== 1'b1) protocol_fail("rvalid dropped before rready");
		check_word("rdata", rdata, data);
	end
	@(posedge ACLK);
	rready <= 1'b1;
	@(negedge ACLK);
	if (rvalid !== 1'b1) protocol_fail("rvalid low when rready was given");
	check_word("rdata", rdata, data);
	@(posedge ACLK);
	rready <= 1'b0;
	@(negedge ACLK);
	if (rvalid !== 1'b0) protocol_fail("rvalid still high after the read handshake");
endtask

`endif

// File: tb_net_cfg.sv
`timescale 1ns/1ps
module tb_net_cfg;
	import cfg_pkg::*;

	typedef enum logic [1:0] {OP_WRITE, OP_READ, OP_CHECK} op_e;

	typedef struct {
		op_e   op;
		addr_t addr;
		word_t data;
		strb_t strb;
		int    hold;
	} entry_t;

	logic  ACLK = 1'b0;
	logic  ARESET;
	logic  awvalid, awready, wvalid, wready, bvalid, bready;
	logic  arvalid, arready, rvalid, rready;
	addr_t awaddr, araddr;
	word_t wdata, rdata;
	strb_t wstrb;
	resp_t bresp, rresp;
	ip_t   cfg_ip, cfg_gateway, cfg_netmask;
	mac_t  cfg_mac;

	entry_t stim_q[$];
	word_t  model_regs[6];

	`include "tb_checks.svh"

	always #20 ACLK = ~ACLK;

	net_cfg_top #(
		.ip_addr      (DEF_IP),
		.gateway_addr (DEF_GATEWAY),
		.netmask_addr (DEF_NETMASK),
		.mac_addr     (DEF_MAC)
	) u_net_cfg_top (.*);

	// word slot in the map, -1 outside it
	function automatic int model_index(input addr_t addr);
		return (addr[1:0] == 2'b00 && addr < 5'h18) ? int'(addr[4:2]) : -1;
	endfunction

	function automatic void model_write(input addr_t addr, input word_t data, input strb_t strb);
		word_t mask;
		int    idx;
		idx  = model_index(addr);
		mask = {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
		if (idx >= 0) begin
			model_regs[idx] = (model_regs[idx] & ~mask) | (data & mask);
		end
	endfunction

	function automatic word_t model_read(input addr_t addr);
		return (model_index(addr) >= 0) ? model_regs[model_index(addr)] : '0;
	endfunction

	function automatic void add_entry(input op_e op, input addr_t addr, input word_t data,
			input strb_t strb);
		stim_q.push_back('{op, addr, data, strb, int'(lcg_next() >> 29)});
	endfunction

	function automatic void build_table();
		word_t d;
		word_t s;
		addr_t a;
		// out of reset
		add_entry(OP_CHECK, '0, '0, '0);
		for (int i = 0; i < 6; i++) begin
			add_entry(OP_READ, addr_t'(4 * i), '0, '0);
		end
		// full words, enable bit kept clear
		for (int i = 0; i < 6; i++) begin
			d = lcg_next();
			if (i == 0) begin
				d[0] = 1'b0;
			end
			add_entry(OP_WRITE, addr_t'(4 * i), d, 4'hF);
			add_entry(OP_READ, addr_t'(4 * i), '0, '0);
		end
		add_entry(OP_CHECK, '0, '0, '0);
		add_entry(OP_WRITE, REG_IP, 32'h1122_3344, 4'b0101);
		add_entry(OP_READ, REG_IP, '0, '0);
		add_entry(OP_WRITE, REG_NETMASK, 32'h5566_7788, 4'b0010);
		add_entry(OP_READ, REG_NETMASK, '0, '0);
		add_entry(OP_WRITE, REG_MAC_HI, 32'hDEAD_BEEF, 4'b1000);
		add_entry(OP_READ, REG_MAC_HI, '0, '0);
		// outside the map
		add_entry(OP_READ, 5'h18, '0, '0);
		add_entry(OP_READ, 5'h1C, '0, '0);
		add_entry(OP_READ, 5'h06, '0, '0);
		add_entry(OP_WRITE, 5'h18, 32'hFFFF_FFFF, 4'hF);
		add_entry(OP_WRITE, 5'h1F, 32'hFFFF_FFFF, 4'hF);
		add_entry(OP_WRITE, 5'h02, 32'hFFFF_FFFF, 4'hF);
		for (int i = 0; i < 6; i++) begin
			add_entry(OP_READ, addr_t'(4 * i), '0, '0);
		end
		add_entry(OP_WRITE, REG_ENA, 32'h0000_0001, 4'b0001);
		add_entry(OP_CHECK, '0, '0, '0);
		add_entry(OP_WRITE, REG_ENA, 32'h0000_0000, 4'hF);
		add_entry(OP_CHECK, '0, '0, '0);
		// random traffic, enable on at the start
		add_entry(OP_WRITE, REG_ENA, 32'h0000_0001, 4'hF);
		for (int i = 0; i < 12; i++) begin
			a = addr_t'(4 * (lcg_next() >> 29));
			d = lcg_next();
			s = lcg_next();
			add_entry(OP_WRITE, a, d, s[3:0]);
			add_entry(OP_READ, a, '0, '0);
		end
		add_entry(OP_CHECK, '0, '0, '0);
	endfunction

	task automatic check_outputs();
		logic ena;
		ena = model_regs[0][0];
		// output stage lags the registers by a cycle
		repeat (2) @(posedge ACLK);
		@(negedge ACLK);
		check_ip("cfg_ip", cfg_ip, ena ? model_regs[1] : DEF_IP);
		check_ip("cfg_gateway", cfg_gateway, ena ? model_regs[2] : DEF_GATEWAY);
		check_ip("cfg_netmask", cfg_netmask, ena ? model_regs[3] : DEF_NETMASK);
		check_mac("cfg_mac", cfg_mac, ena ? {model_regs[4][15:0], model_regs[5]} : DEF_MAC);
	endtask

	initial begin
		word_t rd_val;
		resp_t resp;
		int    total;
		ARESET  <= 1'b1;
		awaddr  <= '0;
		awvalid <= 1'b0;
		wdata   <= '0;
		wstrb   <= '0;
		wvalid  <= 1'b0;
		bready  <= 1'b0;
		araddr  <= '0;
		arvalid <= 1'b0;
		rready  <= 1'b0;
		model_regs = '{default: '0};
		build_table();
		repeat (8) @(posedge ACLK);
		ARESET <= 1'b0;
		foreach (stim_q[i]) begin
			case (stim_q[i].op)
				OP_WRITE: begin
					bus_write(stim_q[i].addr, stim_q[i].data, stim_q[i].strb, stim_q[i].hold, resp);
					check_resp("bresp", resp, RESP_OKAY);
					model_write(stim_q[i].addr, stim_q[i].data, stim_q[i].strb);
				end
				OP_READ: begin
					bus_read(stim_q[i].addr, stim_q[i].hold, rd_val, resp);
					check_resp("rresp", resp, RESP_OKAY);
					check_word("rdata", rd_val, model_read(stim_q[i].addr));
				end
				default: check_outputs();
			endcase
		end
		total = value_errors + timeout_errors + protocol_errors;
		$display("errors: %0d value, %0d timeout, %0d protocol",
			value_errors, timeout_errors, protocol_errors);
		if (total == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

endmodule

// File: list.f
+incdir+.
cfg_pkg.sv
cfg_write_channel.sv
cfg_register_file.sv
cfg_read_channel.sv
cfg_output_stage.sv
net_cfg_top.sv
tb_net_cfg.sv

// File: run_sim.sh
#!/usr/bin/env bash
# builds and runs tb_net_cfg with Verilator, exit status 0 only on a clean run

cd "$(dirname "$0")" || exit 1

OBJ_DIR=obj_dir
BUILD_LOG=build.log
SIM_LOG=sim.log

rm -rf "$OBJ_DIR"

verilator --binary --timing --assert -f list.f --top-module tb_net_cfg \
	-Mdir "$OBJ_DIR" -o tb_net_cfg > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
	cat "$BUILD_LOG"
	echo "build failed"
	exit 1
fi

"./$OBJ_DIR/tb_net_cfg" > "$SIM_LOG" 2>&1
sim_status=$?
cat "$SIM_LOG"
if [ $sim_status -ne 0 ]; then
	echo "simulator exited with status $sim_status"
	exit 1
fi

if grep -q "Something failed" "$SIM_LOG"; then
	echo "testbench reported a failure"
	exit 1
fi

echo "run finished without failures"
exit 0
